//--- src.f
+incdir+.
loader_pkg.sv
wb_pkg.sv
loader_ctrl.sv
prg_tracker.sv
crt_parser.sv
wb_byte_writer.sv
c64_loader.sv
tb_c64_loader.sv

//--- tb_c64_loader_tasks.svh
// ========================================
// Checking and reporting
// ========================================
task automatic abort_run();
	$display("*** TEST FAILED ***");
	$fatal(1, "Simulation stopped after a failure");
endtask

task automatic check_value(input string name, input logic [63:0] actual,
	input logic [63:0] expected);
	if (actual !== expected) begin
		$display("[ERROR] %0d ns %s: actual 0x%0h, expected 0x%0h",
			$time, name, actual, expected);
		abort_run();
	end
endtask

task automatic record_write(input int adr, input loader_pkg::byte_t dat);
	mem_data[adr] = dat;
	if (mem_hits.exists(adr)) begin
		mem_hits[adr] = mem_hits[adr] + 1;
	end else begin
		mem_hits[adr] = 1;
	end
	wr_total = wr_total + 1;
endtask

task automatic clear_memory();
	mem_data.delete();
	mem_hits.delete();
	bank_log.delete();
	wr_total = 0;
endtask

// One write expected at the address, with the given value
task automatic check_mem(input int adr, input loader_pkg::byte_t expected);
	if (!mem_data.exists(adr)) begin
		$display("No memory write seen at address 0x%0h", adr);
		abort_run();
	end else begin
		check_value($sformatf("mem[0x%0h]", adr), mem_data[adr], expected);
		check_value($sformatf("writes to 0x%0h", adr), mem_hits[adr], 1);
	end
endtask

function automatic loader_pkg::byte_t pattern_byte(input loader_pkg::mem_addr_t a);
	return a[7:0] ^ a[15:8] ^ a[23:16] ^ {7'd0, a[24]} ^ 8'h5A;
endfunction

// ========================================
// Waiting and streaming
// ========================================
task automatic wait_for_wait_level(input logic level, input int limit);
	int n;
	n = 0;
	@(negedge clk_sys);
	while (wait_o !== level) begin
		if (n >= limit) begin
			$display("Timeout after %0d cycles waiting for wait_o to become %0b", limit, level);
			abort_run();
		end
		n++;
		@(negedge clk_sys);
	end
endtask

task automatic wait_for_attach(input int limit);
	int n;
	n = 0;
	@(negedge clk_sys);
	while (cart_attached !== 1'b1) begin
		if (n >= limit) begin
			$display("Timeout: cartridge was not attached after %0d cycles", limit);
			abort_run();
		end
		n++;
		@(negedge clk_sys);
	end
endtask

task automatic send_byte(input loader_pkg::dl_addr_t offset, input loader_pkg::byte_t value);
	wait_for_wait_level(1'b0, WAIT_LIMIT);
	@(posedge clk_sys);
	dl.wr   <= 1'b1;
	dl.addr <= offset;
	dl.data <= value;
	@(posedge clk_sys);
	dl.wr <= 1'b0;
endtask

task automatic send_file();
	for (int i = 0; i < file_q.size(); i++) begin
		send_byte(loader_pkg::dl_addr_t'(i), file_q[i]);
	end
endtask

task automatic start_download(input loader_pkg::dl_index_t idx);
	@(posedge clk_sys);
	index_i    <= idx;
	download_i <= 1'b1;
	@(posedge clk_sys);
endtask

task automatic finish_download();
	wait_for_wait_level(1'b0, WAIT_LIMIT);
	@(posedge clk_sys);
	download_i <= 1'b0;
	@(posedge clk_sys);
endtask

// ========================================
// CRT image building
// ========================================
task automatic push_be16(input logic [15:0] v);
	file_q.push_back(v[15:8]);
	file_q.push_back(v[7:0]);
endtask

task automatic push_crt_header(input logic [15:0] id, input loader_pkg::byte_t exrom,
	input loader_pkg::byte_t game);
	for (int i = 0; i < 'h40; i++) begin
		file_q.push_back(8'h00);
	end
	file_q[0]    = 8'h43;
	file_q['h16] = id[15:8];
	file_q['h17] = id[7:0];
	file_q['h18] = exrom;
	file_q['h19] = game;
endtask

task automatic push_chip_packet(input loader_pkg::bank_hdr_t hdr, input int len,
	input loader_pkg::mem_addr_t dest);
	loader_pkg::blk_len_t total;
	total = loader_pkg::blk_len_t'(loader_pkg::CRT_CHIP_HDR_LEN + len);
	// Chip signature
	file_q.push_back(8'h43);
	file_q.push_back(8'h48);
	file_q.push_back(8'h49);
	file_q.push_back(8'h50);
	push_be16(total[31:16]);
	push_be16(total[15:0]);
	file_q.push_back(8'h00);
	file_q.push_back(hdr.bank_type);
	push_be16(hdr.bank_num);
	push_be16(hdr.load_addr);
	push_be16(hdr.bank_size);
	for (int i = 0; i < len; i++) begin
		file_q.push_back(pattern_byte(dest + loader_pkg::mem_addr_t'(i)));
	end
endtask

// BASIC pointers after a PRG load
task automatic check_pointers(input loader_pkg::c64_addr_t start, input loader_pkg::c64_addr_t stop);
	int end_lo [4];
	end_lo = '{'h2D, 'h2F, 'h31, 'hAE};
	check_mem('h2B, start[7:0]);
	check_mem('h2C, start[15:8]);
	check_mem('hAC, start[7:0]);
	check_mem('hAD, start[15:8]);
	for (int i = 0; i < 4; i++) begin
		check_mem(end_lo[i], stop[7:0]);
		check_mem(end_lo[i] + 1, stop[15:8]);
	end
	check_value("meminit writes", wr_total, 12);
endtask

// ========================================
// Directed tests
// ========================================
task automatic test_prg_payload();
	loader_pkg::mem_addr_t a;
	clear_memory();
	start_download(loader_pkg::IDX_PRG);
	send_byte(0, PRG_START[7:0]);
	send_byte(1, PRG_START[15:8]);
	// Load address bytes must not touch memory or hold the host off
	for (int i = 0; i < 4; i++) begin
		@(negedge clk_sys);
		check_value("wait_o", wait_o, 1'b0);
	end
	check_value("writes after load address", wr_total, 0);
	for (int i = 0; i < PRG_LEN; i++) begin
		a = loader_pkg::mem_addr_t'(PRG_START) + loader_pkg::mem_addr_t'(i);
		send_byte(loader_pkg::dl_addr_t'(2 + i), pattern_byte(a));
	end
	wait_for_wait_level(1'b0, WAIT_LIMIT);
	check_value("PRG writes", wr_total, PRG_LEN);
	for (int i = 0; i < PRG_LEN; i++) begin
		a = loader_pkg::mem_addr_t'(PRG_START) + loader_pkg::mem_addr_t'(i);
		check_mem(int'(a), pattern_byte(a));
	end
	check_value("write at 0x0", mem_data.exists(0), 0);
	check_value("write at 0x1", mem_data.exists(1), 0);
endtask

task automatic test_prg_meminit();
	clear_memory();
	finish_download();
	wait_for_wait_level(1'b1, WAIT_LIMIT);
	wait_for_wait_level(1'b0, WALK_LIMIT);
	check_pointers(PRG_START, PRG_START + 16'(PRG_LEN));
endtask

task automatic test_crt_header();
	clear_memory();
	file_q.delete();
	push_crt_header(16'h0020, 8'h01, 8'h00);
	start_download(loader_pkg::IDX_CRT);
	send_file();
	wait_for_wait_level(1'b0, WAIT_LIMIT);
	check_value("cart_hdr_o.id", cart_hdr.id, 16'h0020);
	check_value("cart_hdr_o.exrom", cart_hdr.exrom, 8'h01);
	check_value("cart_hdr_o.game", cart_hdr.game, 8'h00);
	check_value("cart_attached_o", cart_attached, 1'b0);
	check_value("header writes", wr_total, 0);
	finish_download();
	wait_for_attach(WAIT_LIMIT);
endtask

task automatic test_crt_packets();
	loader_pkg::bank_hdr_t hdr_a;
	loader_pkg::bank_hdr_t hdr_b;
	hdr_a.bank_type = 8'h00;
	hdr_a.bank_num  = 16'h0000;
	hdr_a.load_addr = 16'h8000;
	hdr_a.bank_size = 16'h2000;
	hdr_b.bank_type = 8'h02;
	hdr_b.bank_num  = 16'h0001;
	hdr_b.load_addr = 16'hA000;
	hdr_b.bank_size = 16'h2000;
	clear_memory();
	file_q.delete();
	push_crt_header(16'h0013, 8'h00, 8'h01);
	push_chip_packet(hdr_a, CHIP_LEN, CRT_BANK0);
	push_chip_packet(hdr_b, CHIP_LEN, CRT_BANK1);
	start_download(loader_pkg::IDX_CRT_ALT);
	@(negedge clk_sys);
	check_value("cart_attached_o", cart_attached, 1'b0);
	send_file();
	wait_for_wait_level(1'b0, WAIT_LIMIT);
	check_value("CRT writes", wr_total, 2 * CHIP_LEN);
	for (int i = 0; i < CHIP_LEN; i++) begin
		check_mem(int'(CRT_BANK0) + i, pattern_byte(CRT_BANK0 + loader_pkg::mem_addr_t'(i)));
		check_mem(int'(CRT_BANK1) + i, pattern_byte(CRT_BANK1 + loader_pkg::mem_addr_t'(i)));
	end
	check_value("bank_wr_o pulses", bank_log.size(), 2);
	check_value("bank_hdr_o first", bank_log[0], hdr_a);
	check_value("bank_hdr_o second", bank_log[1], hdr_b);
	finish_download();
	wait_for_attach(WAIT_LIMIT);
endtask

task automatic test_back_pressure();
	loader_pkg::mem_addr_t a;
	clear_memory();
	start_download(loader_pkg::IDX_PRG);
	send_byte(0, LONG_START[7:0]);
	send_byte(1, LONG_START[15:8]);
	for (int i = 0; i < LONG_LEN; i++) begin
		a = loader_pkg::mem_addr_t'(LONG_START) + loader_pkg::mem_addr_t'(i);
		send_byte(loader_pkg::dl_addr_t'(2 + i), pattern_byte(a));
	end
	wait_for_wait_level(1'b0, WAIT_LIMIT);
	check_value("long run writes", wr_total, LONG_LEN);
	for (int i = 0; i < LONG_LEN; i++) begin
		a = loader_pkg::mem_addr_t'(LONG_START) + loader_pkg::mem_addr_t'(i);
		check_mem(int'(a), pattern_byte(a));
	end
	clear_memory();
	finish_download();
	wait_for_wait_level(1'b1, WAIT_LIMIT);
	wait_for_wait_level(1'b0, WALK_LIMIT);
	check_pointers(LONG_START, LONG_START + 16'(LONG_LEN));
endtask

//--- tb_c64_loader.sv
`timescale 1ns/1ps

module tb_c64_loader;

	localparam int WAIT_LIMIT = 200;
	localparam int WALK_LIMIT = 3000;

	// PRG test image
	localparam loader_pkg::c64_addr_t PRG_START = 16'h0801;
	localparam int                    PRG_LEN   = 10;
	localparam loader_pkg::c64_addr_t LONG_START = 16'hC000;
	localparam int                    LONG_LEN   = 300;

	// CRT test image
	localparam int                    CHIP_LEN  = 20;
	localparam loader_pkg::mem_addr_t CRT_BANK0 = 25'h100000;
	localparam loader_pkg::mem_addr_t CRT_BANK1 = 25'h102000;

	logic                   clk_sys;
	logic                   reset_n;
	logic                   download_i;
	loader_pkg::dl_index_t  index_i;
	loader_pkg::dl_stream_t dl;
	logic                   wait_o;
	wb_pkg::wb_m2s_t        wb;
	logic                   ack = 1'b0;
	loader_pkg::cart_hdr_t  cart_hdr;
	loader_pkg::bank_hdr_t  bank_hdr;
	logic                   bank_wr;
	logic                   cart_attached;

	// Memory model state
	loader_pkg::byte_t      mem_data [int];
	int                     mem_hits [int];
	int                     wr_total;
	integer                 seed;
	int                     ack_delay;
	logic                   in_cycle = 1'b0;
	logic [24:0]            cyc_adr;
	logic [7:0]             cyc_dat;

	loader_pkg::bank_hdr_t  bank_log [$];
	loader_pkg::byte_t      file_q [$];

	`include "tb_c64_loader_tasks.svh"

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	c64_loader u_c64_loader (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.download_i      (download_i),
		.index_i         (index_i),
		.dl_i            (dl),
		.wait_o          (wait_o),
		.wb_o            (wb),
		.ack_i           (ack),
		.cart_hdr_o      (cart_hdr),
		.bank_hdr_o      (bank_hdr),
		.bank_wr_o       (bank_wr),
		.cart_attached_o (cart_attached)
	);

	// ========================================
	// Wishbone memory model
	// ========================================
	always @(posedge clk_sys) begin
		if (!reset_n) begin
			ack       <= 1'b0;
			in_cycle  <= 1'b0;
			ack_delay <= 0;
		end else if (ack) begin
			ack      <= 1'b0;
			in_cycle <= 1'b0;
		end else if (wb.cyc && wb.stb) begin
			if (!in_cycle) begin
				in_cycle  <= 1'b1;
				cyc_adr   <= wb.adr;
				cyc_dat   <= wb.dat;
				ack_delay <= $unsigned($random(seed)) % 6;
			end else begin
				// Master must hold the cycle steady until ack
				check_value("wb_o.we", wb.we, 1'b1);
				check_value("wb_o.adr", wb.adr, cyc_adr);
				check_value("wb_o.dat", wb.dat, cyc_dat);
				if (ack_delay == 0) begin
					ack <= 1'b1;
					record_write(int'(wb.adr), wb.dat);
				end else begin
					ack_delay <= ack_delay - 1;
				end
			end
		end
	end

	// Bank header pulses
	always @(posedge clk_sys) begin
		if (reset_n && bank_wr) begin
			bank_log.push_back(bank_hdr);
		end
	end

	// ========================================
	// Test sequence
	// ========================================
	initial begin
		seed       = 32'hbb78_97ee;
		wr_total   = 0;
		reset_n    = 1'b0;
		download_i = 1'b0;
		index_i    = '0;
		dl         = '0;
		repeat (2) @(posedge clk_sys);
		reset_n <= 1'b1;
		@(negedge clk_sys);
		check_value("wait_o", wait_o, 1'b0);
		check_value("wb_o.cyc", wb.cyc, 1'b0);
		check_value("wb_o.stb", wb.stb, 1'b0);
		check_value("bank_wr_o", bank_wr, 1'b0);
		check_value("cart_attached_o", cart_attached, 1'b0);

		test_prg_payload();
		test_prg_meminit();
		test_crt_header();
		test_crt_packets();
		test_back_pressure();

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

//--- c64_loader.sv
`timescale 1ns/1ps

module c64_loader (
	input  logic                   clk_sys,
	input  logic                   reset_n,
	input  logic                   download_i,
	input  loader_pkg::dl_index_t  index_i,
	input  loader_pkg::dl_stream_t dl_i,
	output logic                   wait_o,
	output wb_pkg::wb_m2s_t        wb_o,
	input  logic                   ack_i,
	output loader_pkg::cart_hdr_t  cart_hdr_o,
	output loader_pkg::bank_hdr_t  bank_hdr_o,
	output logic                   bank_wr_o,
	output logic                   cart_attached_o
);

	loader_pkg::crt_action_t crt_action;
	loader_pkg::mem_addr_t   walk_addr;
	loader_pkg::mem_addr_t   req_addr;
	loader_pkg::byte_t       req_data;
	loader_pkg::byte_t       ptr_byte;
	logic                    ptr_hit;
	logic                    prg_sel;
	logic                    crt_sel;
	logic                    req_valid;
	logic                    wr_busy;

	// ========================================
	// Control
	// ========================================
	loader_ctrl u_loader_ctrl (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.download_i      (download_i),
		.index_i         (index_i),
		.dl_i            (dl_i),
		.crt_action_i    (crt_action),
		.ptr_hit_i       (ptr_hit),
		.ptr_byte_i      (ptr_byte),
		.wr_busy_i       (wr_busy),
		.req_valid_o     (req_valid),
		.req_addr_o      (req_addr),
		.req_data_o      (req_data),
		.walk_addr_o     (walk_addr),
		.prg_sel_o       (prg_sel),
		.crt_sel_o       (crt_sel),
		.wait_o          (wait_o),
		.cart_attached_o (cart_attached_o)
	);

	// ========================================
	// File parsing and memory port
	// ========================================
	prg_tracker u_prg_tracker (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.dl_i        (dl_i),
		.prg_sel_i   (prg_sel),
		.walk_addr_i (walk_addr),
		.ptr_hit_o   (ptr_hit),
		.ptr_byte_o  (ptr_byte)
	);

	crt_parser u_crt_parser (
		.clk_sys      (clk_sys),
		.reset_n      (reset_n),
		.dl_i         (dl_i),
		.crt_sel_i    (crt_sel),
		.crt_action_o (crt_action),
		.cart_hdr_o   (cart_hdr_o),
		.bank_hdr_o   (bank_hdr_o),
		.bank_wr_o    (bank_wr_o)
	);

	wb_byte_writer u_wb_byte_writer (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.req_valid_i (req_valid),
		.req_addr_i  (req_addr),
		.req_data_i  (req_data),
		.busy_o      (wr_busy),
		.wb_o        (wb_o),
		.ack_i       (ack_i)
	);

endmodule

//--- wb_byte_writer.sv
`timescale 1ns/1ps

module wb_byte_writer (
	input  logic                  clk_sys,
	input  logic                  reset_n,
	input  logic                  req_valid_i,
	input  loader_pkg::mem_addr_t req_addr_i,
	input  loader_pkg::byte_t     req_data_i,
	output logic                  busy_o,
	output wb_pkg::wb_m2s_t       wb_o,
	input  logic                  ack_i
);

	logic                         cyc_q;
	logic                         we_q;
	logic [wb_pkg::WB_ADDR_W-1:0] adr_q;
	logic [wb_pkg::WB_DATA_W-1:0] dat_q;
	logic                         accept;

	// Only one cycle in flight
	assign accept = req_valid_i && !cyc_q;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			cyc_q <= 1'b0;
			we_q  <= 1'b0;
		end else if (accept) begin
			cyc_q <= 1'b1;
			we_q  <= 1'b1;
		end else if (cyc_q && ack_i) begin
			cyc_q <= 1'b0;
			we_q  <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (accept) begin
			adr_q <= req_addr_i;
			dat_q <= req_data_i;
		end
	end

	// Drops in the ack cycle so the requester can release on the same edge
	assign busy_o = cyc_q && !ack_i;
	assign wb_o   = '{cyc: cyc_q, stb: cyc_q, we: we_q, adr: adr_q, dat: dat_q};

endmodule

//--- crt_parser.sv
`timescale 1ns/1ps

module crt_parser (
	input  logic                    clk_sys,
	input  logic                    reset_n,
	input  loader_pkg::dl_stream_t  dl_i,
	input  logic                    crt_sel_i,
	output loader_pkg::crt_action_t crt_action_o,
	output loader_pkg::cart_hdr_t   cart_hdr_o,
	output loader_pkg::bank_hdr_t   bank_hdr_o,
	output logic                    bank_wr_o
);

	localparam int HDR_CNT_W = $clog2(loader_pkg::CRT_CHIP_HDR_LEN);

	loader_pkg::blk_len_t  blk_len;
	logic [HDR_CNT_W-1:0]  hdr_cnt;
	loader_pkg::cart_hdr_t cart_hdr;
	loader_pkg::bank_hdr_t bank_hdr;
	logic                  bank_wr;
	logic                  crt_stb;
	logic                  in_packets;

	assign crt_stb    = dl_i.wr && crt_sel_i;
	assign in_packets = dl_i.addr >= loader_pkg::CRT_DATA_START;

	// ========================================
	// Byte classification
	// ========================================
	always_comb begin
		crt_action_o = loader_pkg::CRT_NONE;
		if (crt_stb) begin
			if (dl_i.addr == '0) begin
				crt_action_o = loader_pkg::CRT_RESTART;
			end else if (in_packets && (hdr_cnt == '0)) begin
				if (blk_len == '0) begin
					crt_action_o = loader_pkg::CRT_ALIGN;
				end else begin
					crt_action_o = loader_pkg::CRT_PAYLOAD;
				end
			end
		end
	end

	// Packet length and header position
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			blk_len <= '0;
			hdr_cnt <= '0;
			bank_wr <= 1'b0;
		end else begin
			bank_wr <= 1'b0;
			if (crt_stb) begin
				if (dl_i.addr == '0) begin
					blk_len <= '0;
					hdr_cnt <= '0;
				end else if (in_packets) begin
					if ((blk_len == '0) && (hdr_cnt == '0)) begin
						hdr_cnt <= HDR_CNT_W'(1);
					end else if (hdr_cnt != '0) begin
						// Wraps to zero after the last header byte
						hdr_cnt <= hdr_cnt + 1'b1;
						case (hdr_cnt)
							HDR_CNT_W'(4):  blk_len[31:24] <= dl_i.data;
							HDR_CNT_W'(5):  blk_len[23:16] <= dl_i.data;
							HDR_CNT_W'(6):  blk_len[15:8]  <= dl_i.data;
							HDR_CNT_W'(7):  blk_len[7:0]   <= dl_i.data;
							HDR_CNT_W'(8):  blk_len <= blk_len -
								loader_pkg::blk_len_t'(loader_pkg::CRT_CHIP_HDR_LEN);
							HDR_CNT_W'(15): bank_wr <= 1'b1;
							default: ;
						endcase
					end else begin
						blk_len <= blk_len - 1'b1;
					end
				end
			end
		end
	end

	// ========================================
	// Header fields
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (crt_stb) begin
			case (dl_i.addr)
				25'h016: cart_hdr.id[15:8] <= dl_i.data;
				25'h017: cart_hdr.id[7:0]  <= dl_i.data;
				25'h018: cart_hdr.exrom    <= dl_i.data;
				25'h019: cart_hdr.game     <= dl_i.data;
				default: ;
			endcase
			if (in_packets) begin
				case (hdr_cnt)
					HDR_CNT_W'(9):  bank_hdr.bank_type       <= dl_i.data;
					HDR_CNT_W'(10): bank_hdr.bank_num[15:8]  <= dl_i.data;
					HDR_CNT_W'(11): bank_hdr.bank_num[7:0]   <= dl_i.data;
					HDR_CNT_W'(12): bank_hdr.load_addr[15:8] <= dl_i.data;
					HDR_CNT_W'(13): bank_hdr.load_addr[7:0]  <= dl_i.data;
					HDR_CNT_W'(14): bank_hdr.bank_size[15:8] <= dl_i.data;
					HDR_CNT_W'(15): bank_hdr.bank_size[7:0]  <= dl_i.data;
					default: ;
				endcase
			end
		end
	end

	assign cart_hdr_o = cart_hdr;
	assign bank_hdr_o = bank_hdr;
	assign bank_wr_o  = bank_wr;

endmodule

//--- prg_tracker.sv
`timescale 1ns/1ps

module prg_tracker (
	input  logic                   clk_sys,
	input  logic                   reset_n,
	input  loader_pkg::dl_stream_t dl_i,
	input  logic                   prg_sel_i,
	input  loader_pkg::mem_addr_t  walk_addr_i,
	output logic                   ptr_hit_o,
	output loader_pkg::byte_t      ptr_byte_o
);

	loader_pkg::c64_addr_t start_addr;
	loader_pkg::c64_addr_t end_addr;

	// End address follows the payload, one past the last byte
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			start_addr <= '0;
			end_addr   <= '0;
		end else if (dl_i.wr && prg_sel_i) begin
			if (dl_i.addr == '0) begin
				start_addr[7:0] <= dl_i.data;
				end_addr[7:0]   <= dl_i.data;
			end else if (dl_i.addr == loader_pkg::dl_addr_t'(1)) begin
				start_addr[15:8] <= dl_i.data;
				end_addr[15:8]   <= dl_i.data;
			end else begin
				end_addr <= end_addr + 1'b1;
			end
		end
	end

	// ========================================
	// BASIC zero-page pointers
	// ========================================
	always_comb begin
		ptr_hit_o  = 1'b1;
		ptr_byte_o = '0;
		case (walk_addr_i)
			// TXT and SAVE_START
			25'h02B, 25'h0AC: ptr_byte_o = start_addr[7:0];
			25'h02C, 25'h0AD: ptr_byte_o = start_addr[15:8];
			// VAR, ARY, STR and LOAD_END
			25'h02D, 25'h02F, 25'h031, 25'h0AE: ptr_byte_o = end_addr[7:0];
			25'h02E, 25'h030, 25'h032, 25'h0AF: ptr_byte_o = end_addr[15:8];
			default: ptr_hit_o = 1'b0;
		endcase
	end

endmodule

//--- loader_ctrl.sv
`timescale 1ns/1ps

module loader_ctrl (
	input  logic                       clk_sys,
	input  logic                       reset_n,
	input  logic                       download_i,
	input  loader_pkg::dl_index_t      index_i,
	input  loader_pkg::dl_stream_t     dl_i,
	input  loader_pkg::crt_action_t    crt_action_i,
	input  logic                       ptr_hit_i,
	input  loader_pkg::byte_t          ptr_byte_i,
	input  logic                       wr_busy_i,
	output logic                       req_valid_o,
	output loader_pkg::mem_addr_t      req_addr_o,
	output loader_pkg::byte_t          req_data_o,
	output loader_pkg::mem_addr_t      walk_addr_o,
	output logic                       prg_sel_o,
	output logic                       crt_sel_o,
	output logic                       wait_o,
	output logic                       cart_attached_o
);

	loader_pkg::loader_state_t state;
	loader_pkg::loader_state_t ret_state;
	loader_pkg::loader_state_t run_state;
	loader_pkg::mem_addr_t     load_addr;
	loader_pkg::mem_addr_t     walk_addr;
	loader_pkg::mem_addr_t     req_addr;
	loader_pkg::byte_t         req_data;
	logic                      req_pending;
	logic                      wait_q;
	logic                      cart_attached_q;

	logic prg_sel;
	logic crt_sel;
	logic stream_stb;
	logic prg_lo;
	logic prg_hi;
	logic crt_restart;
	logic crt_align;
	logic pay_wr;
	logic meminit_hit;

	// ========================================
	// Stream decode
	// ========================================
	assign prg_sel = download_i && (index_i == loader_pkg::IDX_PRG);
	assign crt_sel = download_i && ((index_i == loader_pkg::IDX_CRT) ||
		(index_i == loader_pkg::IDX_CRT_ALT));

	assign run_state = prg_sel ? loader_pkg::PRG :
		crt_sel ? loader_pkg::CRT : loader_pkg::IDLE;

	// Host bytes are only taken while no write is outstanding
	assign stream_stb = dl_i.wr && (state inside {loader_pkg::IDLE, loader_pkg::PRG,
		loader_pkg::CRT});

	// First two PRG bytes are the load address
	assign prg_lo      = stream_stb && prg_sel && (dl_i.addr == '0);
	assign prg_hi      = stream_stb && prg_sel && (dl_i.addr == loader_pkg::dl_addr_t'(1));
	assign crt_restart = stream_stb && crt_sel && (crt_action_i == loader_pkg::CRT_RESTART);
	assign crt_align   = stream_stb && crt_sel && (crt_action_i == loader_pkg::CRT_ALIGN);
	assign pay_wr      = (stream_stb && prg_sel && (dl_i.addr > loader_pkg::dl_addr_t'(1))) ||
		(stream_stb && crt_sel && (crt_action_i == loader_pkg::CRT_PAYLOAD));

	assign meminit_hit = (state == loader_pkg::MEMINIT) &&
		(walk_addr != loader_pkg::MEMINIT_END) && ptr_hit_i;

	// ========================================
	// Phase state machine
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state           <= loader_pkg::IDLE;
			ret_state       <= loader_pkg::IDLE;
			req_pending     <= 1'b0;
			wait_q          <= 1'b0;
			cart_attached_q <= 1'b0;
			walk_addr       <= '0;
		end else begin
			case (state)
				loader_pkg::IDLE: begin
					state <= run_state;
					// A new cartridge replaces the old one
					if (crt_sel) begin
						cart_attached_q <= 1'b0;
					end
				end
				loader_pkg::PRG: begin
					if (!download_i) begin
						state     <= loader_pkg::MEMINIT;
						wait_q    <= 1'b1;
						walk_addr <= '0;
					end
				end
				loader_pkg::CRT: begin
					if (!download_i) begin
						state           <= loader_pkg::IDLE;
						cart_attached_q <= 1'b1;
					end
				end
				loader_pkg::MEMINIT: begin
					if (walk_addr == loader_pkg::MEMINIT_END) begin
						state  <= loader_pkg::IDLE;
						wait_q <= 1'b0;
					end else begin
						walk_addr <= walk_addr + 1'b1;
						if (meminit_hit) begin
							req_pending <= 1'b1;
							ret_state   <= loader_pkg::MEMINIT;
							state       <= loader_pkg::WRITE_WAIT;
						end
					end
				end
				loader_pkg::WRITE_WAIT: begin
					if (req_pending) begin
						if (!wr_busy_i) begin
							req_pending <= 1'b0;
						end
					end else if (!wr_busy_i) begin
						// Bus cycle has been acked
						state <= ret_state;
						if (ret_state != loader_pkg::MEMINIT) begin
							wait_q <= 1'b0;
						end
					end
				end
				default: begin
					state <= loader_pkg::IDLE;
				end
			endcase

			if (pay_wr) begin
				req_pending <= 1'b1;
				wait_q      <= 1'b1;
				ret_state   <= run_state;
				state       <= loader_pkg::WRITE_WAIT;
			end
		end
	end

	// ========================================
	// Load address and request data
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (prg_lo) begin
			load_addr <= loader_pkg::mem_addr_t'(dl_i.data);
		end else if (prg_hi) begin
			load_addr[15:8] <= dl_i.data;
		end else if (crt_restart) begin
			load_addr <= loader_pkg::CRT_BASE;
		end else if (crt_align) begin
			// Next chip packet starts on an 8 KB boundary
			if (load_addr[loader_pkg::CRT_ALIGN_BITS-1:0] != '0) begin
				load_addr <= {load_addr[loader_pkg::MEM_ADDR_W-1:loader_pkg::CRT_ALIGN_BITS] + 1'b1,
					{loader_pkg::CRT_ALIGN_BITS{1'b0}}};
			end
		end else if (pay_wr) begin
			req_addr  <= load_addr;
			req_data  <= dl_i.data;
			load_addr <= load_addr + 1'b1;
		end else if (meminit_hit) begin
			req_addr <= walk_addr;
			req_data <= ptr_byte_i;
		end
	end

	assign req_valid_o     = req_pending && !wr_busy_i;
	assign req_addr_o      = req_addr;
	assign req_data_o      = req_data;
	assign walk_addr_o     = walk_addr;
	assign prg_sel_o       = prg_sel;
	assign crt_sel_o       = crt_sel;
	assign wait_o          = wait_q;
	assign cart_attached_o = cart_attached_q;

endmodule

//--- wb_pkg.sv
package wb_pkg;

	// ========================================
	// Wishbone bus widths
	// ========================================
	localparam int WB_ADDR_W = 25;
	localparam int WB_DATA_W = 8;

	// Master to slave signals, byte wide writes only
	typedef struct packed {
		logic                 cyc;
		logic                 stb;
		logic                 we;
		logic [WB_ADDR_W-1:0] adr;
		logic [WB_DATA_W-1:0] dat;
	} wb_m2s_t;

endpackage

//--- loader_pkg.sv
package loader_pkg;

	// ========================================
	// Widths
	// ========================================
	localparam int BYTE_W     = 8;
	localparam int MEM_ADDR_W = 25;
	localparam int C64_ADDR_W = 16;
	localparam int DL_ADDR_W  = 25;
	localparam int BLK_LEN_W  = 32;
	localparam int DL_INDEX_W = 8;

	typedef logic [BYTE_W-1:0]     byte_t;
	typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
	typedef logic [C64_ADDR_W-1:0] c64_addr_t;
	typedef logic [DL_ADDR_W-1:0]  dl_addr_t;
	typedef logic [BLK_LEN_W-1:0]  blk_len_t;
	typedef logic [DL_INDEX_W-1:0] dl_index_t;

	// ========================================
	// File types and memory layout
	// ========================================
	localparam dl_index_t IDX_PRG          = 8'h04;
	localparam dl_index_t IDX_CRT          = 8'h05;
	localparam dl_index_t IDX_CRT_ALT      = 8'hC0;
	localparam mem_addr_t CRT_BASE         = 25'h100000;
	localparam dl_addr_t  CRT_DATA_START   = 25'h000040;
	localparam int        CRT_CHIP_HDR_LEN = 16;
	localparam int        CRT_ALIGN_BITS   = 13;
	// Zero-page walk stops here
	localparam mem_addr_t MEMINIT_END      = 25'h000100;

	// ========================================
	// Loader types
	// ========================================
	typedef struct packed {
		logic     wr;
		dl_addr_t addr;
		byte_t    data;
	} dl_stream_t;

	typedef struct packed {
		logic [15:0] id;
		byte_t       exrom;
		byte_t       game;
	} cart_hdr_t;

	typedef struct packed {
		byte_t       bank_type;
		logic [15:0] bank_num;
		c64_addr_t   load_addr;
		logic [15:0] bank_size;
	} bank_hdr_t;

	typedef enum logic [1:0] {
		CRT_NONE,
		CRT_RESTART,
		CRT_ALIGN,
		CRT_PAYLOAD
	} crt_action_t;

	typedef enum logic [2:0] {
		IDLE,
		PRG,
		CRT,
		MEMINIT,
		WRITE_WAIT
	} loader_state_t;

endpackage
